// File: rtl/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// instruction lanes fetched per cycle
`define FETCH_WIDTH 2

// direct-mapped cache of 64-bit lines
`define ICACHE_LINES 32

// direct-mapped branch target buffer
`define BTB_ENTRIES 16

// addi x0, x0, 0
`define NOP 32'h0000_0013

// one-bit constants
`define TRUE 1'b1
`define FALSE 1'b0

`endif

// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [31:0] addr_t;

    // two instructions per block
    typedef logic [63:0] mem_block_t;

    // zero means not accepted / no data
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        cmd_none = 2'd0,
        cmd_load = 2'd1
    } mem_command_e;

    typedef struct packed {
        mem_command_e command;
        addr_t        addr;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t   transaction_tag;
        mem_block_t data;
        mem_tag_t   data_tag;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    import mem_pkg::*;

    typedef logic [31:0] inst_t;

    // prediction for a single lane
    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t next_pc;
    } pc_entry_t;

    // one lane handed to decode
    typedef struct packed {
        logic  valid;
        inst_t inst;
        addr_t pc;
        addr_t npc;
        logic  predict_taken;
        addr_t predict_target;
    } if_id_packet_t;

    // one resolved branch from the reorder buffer
    typedef struct packed {
        logic  valid;
        logic  mispredict;
        logic  taken;
        addr_t branch_pc;
        addr_t resolve_target;
    } rob_resolve_t;

endpackage

`default_nettype wire

// File: rtl/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module branch_predictor (
    input  logic                                      clock,
    input  logic                                      reset,
    input  mem_pkg::addr_t                            pc_start,
    input  fetch_pkg::rob_resolve_t                   rob_resolve,
    output fetch_pkg::pc_entry_t [`FETCH_WIDTH-1:0]   target_pc
);
    import mem_pkg::*;

    localparam int IDX_BITS = $clog2(`BTB_ENTRIES);
    localparam int TAG_LSB  = IDX_BITS + 2;

    typedef logic [IDX_BITS-1:0] btb_idx_t;
    typedef logic [31-TAG_LSB:0] btb_tag_t;

    logic [`BTB_ENTRIES-1:0] btb_valid;
    btb_tag_t                btb_tag    [`BTB_ENTRIES];
    addr_t                   btb_target [`BTB_ENTRIES];

    btb_idx_t resolve_idx;
    logic     resolve_match;

    assign resolve_idx   = rob_resolve.branch_pc[TAG_LSB-1:2];
    assign resolve_match = btb_valid[resolve_idx]
                           && btb_tag[resolve_idx] == rob_resolve.branch_pc[31:TAG_LSB];

    // lookup drops lanes past the first taken one
    always_comb begin
        logic     blocked;
        addr_t    lane_pc;
        btb_idx_t idx;
        blocked = `FALSE;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_pc = pc_start + addr_t'(4 * i);
            idx     = lane_pc[TAG_LSB-1:2];
            target_pc[i].valid = !blocked;
            if (btb_valid[idx] && btb_tag[idx] == lane_pc[31:TAG_LSB]) begin
                target_pc[i].taken   = `TRUE;
                target_pc[i].next_pc = btb_target[idx];
                blocked              = `TRUE;
            end else begin
                target_pc[i].taken   = `FALSE;
                target_pc[i].next_pc = lane_pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
        end else if (rob_resolve.valid) begin
            if (rob_resolve.taken) begin
                btb_valid[resolve_idx] <= `TRUE;
            end else if (resolve_match) begin
                // a not-taken branch stops being predicted
                btb_valid[resolve_idx] <= `FALSE;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rob_resolve.valid && rob_resolve.taken) begin
            btb_tag[resolve_idx]    <= rob_resolve.branch_pc[31:TAG_LSB];
            btb_target[resolve_idx] <= rob_resolve.resolve_target;
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module icache (
    input  logic                                   clock,
    input  logic                                   reset,
    input  mem_pkg::addr_t     [`FETCH_WIDTH-1:0]  lane_addr,
    input  logic               [`FETCH_WIDTH-1:0]  lane_req,
    input  logic                                   flush_miss,
    output mem_pkg::mem_req_t                      mem_req,
    input  mem_pkg::mem_rsp_t                      mem_rsp,
    output mem_pkg::mem_block_t [`FETCH_WIDTH-1:0] lane_data,
    output logic               [`FETCH_WIDTH-1:0]  lane_hit
);
    import mem_pkg::*;

    localparam int OFFSET_BITS = 3;
    localparam int INDEX_BITS  = $clog2(`ICACHE_LINES);
    localparam int TAG_LSB     = INDEX_BITS + OFFSET_BITS;

    typedef logic [INDEX_BITS-1:0] line_idx_t;
    typedef logic [31-TAG_LSB:0]   line_tag_t;

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_wait
    } miss_state_e;

    logic [`ICACHE_LINES-1:0] line_valid;
    line_tag_t                line_tag  [`ICACHE_LINES];
    mem_block_t               line_data [`ICACHE_LINES];

    miss_state_e state, state_next;
    addr_t       miss_addr;
    mem_tag_t    miss_tag;
    logic        miss_found;
    addr_t       miss_lane_addr;
    logic        start_miss;
    logic        accepted;
    logic        fill_done;

    function automatic line_idx_t line_index(input addr_t addr);
        return addr[TAG_LSB-1:OFFSET_BITS];
    endfunction

    // parallel tag compare per lane
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_data[i] = line_data[line_index(lane_addr[i])];
            lane_hit[i]  = lane_req[i]
                           && line_valid[line_index(lane_addr[i])]
                           && line_tag[line_index(lane_addr[i])] == lane_addr[i][31:TAG_LSB];
        end
    end

    // lowest requesting lane that misses
    always_comb begin
        miss_found     = `FALSE;
        miss_lane_addr = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (!miss_found && lane_req[i] && !lane_hit[i]) begin
                miss_found     = `TRUE;
                miss_lane_addr = lane_addr[i];
            end
        end
    end

    assign start_miss = state == st_idle && miss_found && !flush_miss;
    assign accepted   = state == st_request && mem_rsp.transaction_tag != '0;
    assign fill_done  = state == st_wait && mem_rsp.data_tag != '0
                        && mem_rsp.data_tag == miss_tag;

    always_comb begin
        state_next = state;
        case (state)
            st_idle:    if (start_miss) state_next = st_request;
            st_request: if (accepted) state_next = st_wait;
            st_wait:    if (fill_done) state_next = st_idle;
            default:    state_next = st_idle;
        endcase
    end

    // load held until memory returns a nonzero tag
    always_comb begin
        mem_req.command = cmd_none;
        mem_req.addr    = '0;
        if (state == st_request) begin
            mem_req.command = cmd_load;
            mem_req.addr    = miss_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_idle;
            line_valid <= '0;
        end else begin
            state <= state_next;
            if (fill_done) begin
                line_valid[line_index(miss_addr)] <= `TRUE;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start_miss) begin
            miss_addr <= {miss_lane_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
        if (accepted) begin
            miss_tag <= mem_rsp.transaction_tag;
        end
        if (fill_done) begin
            line_tag[line_index(miss_addr)]  <= miss_addr[31:TAG_LSB];
            line_data[line_index(miss_addr)] <= mem_rsp.data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/stage_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module stage_fetch (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        stall,
    input  fetch_pkg::rob_resolve_t                     rob_resolve,
    output mem_pkg::mem_req_t                           mem_req,
    input  mem_pkg::mem_rsp_t                           mem_rsp,
    output fetch_pkg::if_id_packet_t [`FETCH_WIDTH-1:0] if_id_packet
);
    import mem_pkg::*;
    import fetch_pkg::*;

    addr_t pc_start;
    addr_t next_pc_start;
    logic  redirect;

    pc_entry_t  [`FETCH_WIDTH-1:0] target_pc;
    addr_t      [`FETCH_WIDTH-1:0] lane_addr;
    logic       [`FETCH_WIDTH-1:0] lane_req;
    logic       [`FETCH_WIDTH-1:0] lane_hit;
    logic       [`FETCH_WIDTH-1:0] lane_valid;
    mem_block_t [`FETCH_WIDTH-1:0] lane_data;

    assign redirect = rob_resolve.valid && rob_resolve.mispredict;

    branch_predictor u_predictor (
        .clock       (clock),
        .reset       (reset),
        .pc_start    (pc_start),
        .rob_resolve (rob_resolve),
        .target_pc   (target_pc)
    );

    icache u_icache (
        .clock      (clock),
        .reset      (reset),
        .lane_addr  (lane_addr),
        .lane_req   (lane_req),
        .flush_miss (redirect),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .lane_data  (lane_data),
        .lane_hit   (lane_hit)
    );

    // each later lane follows the prediction of the one before
    always_comb begin
        lane_addr[0] = pc_start;
        for (int i = 1; i < `FETCH_WIDTH; i++) begin
            lane_addr[i] = target_pc[i-1].next_pc;
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_req[i] = target_pc[i].valid;
        end
    end

    // valid prefix ends at the first miss or on a redirect
    always_comb begin
        logic prefix;
        prefix = !redirect;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            prefix        = prefix && target_pc[i].valid && lane_hit[i];
            lane_valid[i] = prefix;
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if_id_packet[i].valid = lane_valid[i];
            if (!lane_valid[i]) begin
                if_id_packet[i].inst = `NOP;
            end else if (lane_addr[i][2]) begin
                if_id_packet[i].inst = lane_data[i][63:32];
            end else begin
                if_id_packet[i].inst = lane_data[i][31:0];
            end
            if_id_packet[i].pc             = lane_addr[i];
            if_id_packet[i].npc            = lane_addr[i] + 32'd4;
            if_id_packet[i].predict_taken  = target_pc[i].taken;
            if_id_packet[i].predict_target = target_pc[i].next_pc;
        end
    end

    // redirect wins over stall, stall over advance
    always_comb begin
        next_pc_start = pc_start;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (lane_valid[i]) begin
                next_pc_start = target_pc[i].next_pc;
            end
        end
        if (stall) begin
            next_pc_start = pc_start;
        end
        if (redirect) begin
            next_pc_start = rob_resolve.resolve_target;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_start <= '0;
        end else begin
            pc_start <= next_pc_start;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter int unsigned SEED     = 1,
    parameter logic [31:0] INST_XOR = 32'h0
) (
    input  logic              clock,
    input  logic              reset,
    input  mem_pkg::mem_req_t mem_req,
    output mem_pkg::mem_rsp_t mem_rsp
);
    import mem_pkg::*;

    logic       busy;
    int         accept_wait;
    int         latency;
    addr_t      load_addr;
    mem_tag_t   load_tag;
    mem_tag_t   next_tag;
    mem_block_t out_data;
    mem_tag_t   out_tag;

    // each word holds its own byte address xor a constant
    function automatic mem_block_t block_at(input addr_t addr);
        addr_t base;
        base = {addr[31:3], 3'b000};
        return {(base + 32'd4) ^ INST_XOR, base ^ INST_XOR};
    endfunction

    // acceptance shows in the same cycle as the load
    assign mem_rsp.transaction_tag = (!busy && mem_req.command == cmd_load && accept_wait == 0)
                                     ? next_tag : 4'd0;
    assign mem_rsp.data            = out_data;
    assign mem_rsp.data_tag        = out_tag;

    initial begin
        void'($urandom(SEED));
        busy        <= 1'b0;
        accept_wait <= 0;
        latency     <= 0;
        next_tag    <= 4'd1;
        out_tag     <= 4'd0;
        out_data    <= '0;
        forever begin
            @(posedge clock);
            if (reset) begin
                busy        <= 1'b0;
                accept_wait <= 0;
                next_tag    <= 4'd1;
                out_tag     <= 4'd0;
            end else begin
                out_tag <= 4'd0;
                if (busy) begin
                    if (latency <= 1) begin
                        out_tag  <= load_tag;
                        out_data <= block_at(load_addr);
                        busy     <= 1'b0;
                    end else begin
                        latency <= latency - 1;
                    end
                end else if (mem_req.command == cmd_load) begin
                    if (accept_wait == 0) begin
                        busy        <= 1'b1;
                        load_addr   <= mem_req.addr;
                        load_tag    <= next_tag;
                        // data 3 to 8 cycles after acceptance
                        latency     <= 3 + int'($urandom % 6);
                        accept_wait <= int'($urandom % 4);
                        next_tag    <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                    end else begin
                        accept_wait <= accept_wait - 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_stage_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module tb_stage_fetch;
    import mem_pkg::*;
    import fetch_pkg::*;

    localparam int unsigned RAND_SEED       = 98346;
    localparam logic [31:0] INST_XOR        = 32'h5ca1_ab1e;
    localparam int          NUM_TESTS       = 6;
    localparam int          CYCLES_PER_TEST = 400;
    localparam int          TIMEOUT_NS      = 2 * NUM_TESTS * CYCLES_PER_TEST * 4;

    logic                             clock;
    logic                             reset;
    logic                             stall;
    rob_resolve_t                     rob_resolve;
    mem_req_t                         mem_req;
    mem_rsp_t                         mem_rsp;
    if_id_packet_t [`FETCH_WIDTH-1:0] if_id_packet;

    int    errors;
    int    checks;
    addr_t expect_pc;
    // single branch target buffer entry as the tests expect it
    logic  btb_valid;
    addr_t btb_pc;
    addr_t btb_target;
    // address range that must not be loaded again
    logic  guard_on;
    addr_t guard_lo;
    addr_t guard_hi;

    stage_fetch u_dut (
        .clock        (clock),
        .reset        (reset),
        .stall        (stall),
        .rob_resolve  (rob_resolve),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .if_id_packet (if_id_packet)
    );

    tb_mem_model #(.SEED(RAND_SEED), .INST_XOR(INST_XOR)) u_mem (
        .clock   (clock),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #2 clock = ~clock;

    function automatic rob_resolve_t make_resolve(input logic mispredict, input logic taken,
                                                  input addr_t branch_pc, input addr_t target);
        rob_resolve_t r;
        r.valid          = 1'b1;
        r.mispredict     = mispredict;
        r.taken          = taken;
        r.branch_pc      = branch_pc;
        r.resolve_target = target;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    // drive on the falling edge and sample 1 ns later
    task automatic advance(input rob_resolve_t r, input logic hold);
        @(negedge clock);
        rob_resolve = r;
        stall       = hold;
        #1;
    endtask

    task automatic check_no_lanes;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            check_value($sformatf("if_id_packet[%0d].valid", i), 32'(if_id_packet[i].valid), 0);
        end
    endtask

    // stall until the bundle at expect_pc has a valid lane 0
    task automatic hold_until_valid(input int limit);
        int cycles;
        cycles = 0;
        advance('0, 1'b1);
        check_value("if_id_packet[0].pc", if_id_packet[0].pc, expect_pc);
        while (!if_id_packet[0].valid && cycles < limit) begin
            advance('0, 1'b1);
            cycles++;
            check_value("if_id_packet[0].pc", if_id_packet[0].pc, expect_pc);
        end
        if (!if_id_packet[0].valid) begin
            report_failure("lane 0 did not become valid while stalled");
        end
    endtask

    task automatic check_bundle(inout int got);
        logic          in_prefix;
        logic          exp_taken;
        if_id_packet_t pkt;
        in_prefix = 1'b1;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            pkt = if_id_packet[i];
            if (!pkt.valid) begin
                check_value($sformatf("if_id_packet[%0d].inst", i), pkt.inst, `NOP);
                in_prefix = 1'b0;
            end else if (!in_prefix) begin
                report_failure($sformatf("lane %0d is valid after an invalid or taken lane", i));
            end else begin
                exp_taken = btb_valid && expect_pc == btb_pc;
                check_value($sformatf("if_id_packet[%0d].pc", i), pkt.pc, expect_pc);
                check_value($sformatf("if_id_packet[%0d].inst", i), pkt.inst,
                            expect_pc ^ INST_XOR);
                check_value($sformatf("if_id_packet[%0d].npc", i), pkt.npc, expect_pc + 32'd4);
                check_value($sformatf("if_id_packet[%0d].predict_taken", i),
                            32'(pkt.predict_taken), 32'(exp_taken));
                check_value($sformatf("if_id_packet[%0d].predict_target", i),
                            pkt.predict_target, exp_taken ? btb_target : expect_pc + 32'd4);
                got++;
                if (exp_taken) begin
                    expect_pc = btb_target;
                    in_prefix = 1'b0;
                end else begin
                    expect_pc = expect_pc + 32'd4;
                end
            end
        end
    endtask

    task automatic consume(input int count, input int limit);
        int got;
        int cycles;
        got    = 0;
        cycles = 0;
        while (got < count && cycles < limit) begin
            advance('0, 1'b0);
            cycles++;
            if (guard_on && mem_req.command == cmd_load
                && mem_req.addr >= guard_lo && mem_req.addr < guard_hi) begin
                report_failure($sformatf("load of %h issued for an address already cached",
                                         mem_req.addr));
            end
            check_bundle(got);
        end
        if (got < count) begin
            report_failure($sformatf("only %0d of %0d instructions fetched in %0d cycles",
                                     got, count, limit));
        end
    endtask

    task automatic test_reset_fetch;
        logic load_seen;
        logic lane_seen;
        int   cycles;
        int   got;
        load_seen = 1'b0;
        lane_seen = 1'b0;
        cycles    = 0;
        got       = 0;
        while (!lane_seen && cycles < 64) begin
            advance('0, 1'b0);
            cycles++;
            if (mem_req.command == cmd_load && !load_seen) begin
                load_seen = 1'b1;
                check_value("mem_req.addr", mem_req.addr, 32'h0);
            end
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (if_id_packet[i].valid) begin
                    lane_seen = 1'b1;
                end
            end
        end
        if (!lane_seen) begin
            report_failure("no lane became valid after reset");
        end else begin
            if (!load_seen) begin
                report_failure("a lane became valid before any load was issued");
            end
            expect_pc = 32'h0;
            check_bundle(got);
        end
    endtask

    task automatic test_sequential;
        consume(40, 16 * 40 + 16);
    endtask

    task automatic test_stall;
        hold_until_valid(64);
        repeat (6) begin
            advance('0, 1'b1);
            check_value("if_id_packet[0].pc", if_id_packet[0].pc, expect_pc);
            check_value("if_id_packet[0].valid", 32'(if_id_packet[0].valid), 32'd1);
        end
        consume(12, 16 * 12 + 16);
    endtask

    task automatic test_redirect(input addr_t target);
        // the redirect must drop a bundle that would otherwise be valid
        hold_until_valid(64);
        advance(make_resolve(1'b1, 1'b0, 32'h0000_1000, target), 1'b0);
        check_no_lanes();
        expect_pc = target;
        consume(8, 16 * 8 + 16);
    endtask

    task automatic test_hits;
        addr_t start;
        start = expect_pc - 32'd32;
        advance(make_resolve(1'b1, 1'b0, 32'h0000_1000, start), 1'b0);
        check_no_lanes();
        expect_pc = start;
        guard_lo  = start;
        guard_hi  = start + 32'd32;
        guard_on  = 1'b1;
        // every bundle hits with both lanes valid
        consume(8, 6);
        guard_on = 1'b0;
    endtask

    task automatic test_btb(input addr_t branch, input addr_t target);
        advance(make_resolve(1'b0, 1'b1, branch, target), 1'b0);
        btb_valid  = 1'b1;
        btb_pc     = branch;
        btb_target = target;
        advance(make_resolve(1'b1, 1'b0, 32'h0000_1000, branch - 32'd8), 1'b0);
        check_no_lanes();
        expect_pc = branch - 32'd8;
        consume(6, 16 * 6 + 16);
        // not-taken resolve clears the entry and redirects back
        advance(make_resolve(1'b1, 1'b0, branch, branch - 32'd8), 1'b0);
        check_no_lanes();
        btb_valid = 1'b0;
        expect_pc = branch - 32'd8;
        consume(6, 16 * 6 + 16);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the tests did not complete", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        stall       = 1'b0;
        rob_resolve = '0;
        errors      = 0;
        checks      = 0;
        expect_pc   = '0;
        btb_valid   = 1'b0;
        btb_pc      = '0;
        btb_target  = '0;
        guard_on    = 1'b0;
        guard_lo    = '0;
        guard_hi    = '0;
        repeat (3) @(negedge clock);
        reset = 1'b0;

        test_reset_fetch();
        test_sequential();
        test_stall();
        test_redirect(32'h0000_0300);
        test_hits();
        test_btb(32'h0000_0048, 32'h0000_0180);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/fetch_pkg.sv
rtl/branch_predictor.sv
rtl/icache.sv
rtl/stage_fetch.sv
sim/tb_mem_model.sv
sim/tb_stage_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f compile.f --top-module tb_stage_fetch \
    --Mdir obj_dir -o tb_stage_fetch
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_stage_fetch > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0
